//--- Bender.yml
package:
  name: ast_tx

sources:
  - files:
      - verilog/tx_stream_pkg.sv
      - verilog/tx_fifo.sv
      - verilog/tlp_packer.sv
      - verilog/stream_out.sv
      - verilog/ast_tx_top.sv
  - target: simulation
    files:
      - verif/ast_tx_assertions.sv
      - verif/ast_tx_tb.sv

//--- project.f
verilog/tx_stream_pkg.sv
verilog/tx_fifo.sv
verilog/tlp_packer.sv
verilog/stream_out.sv
verilog/ast_tx_top.sv
verif/ast_tx_assertions.sv
verif/ast_tx_tb.sv

//--- verif/ast_tx_assertions.sv
// Protocol checker for the transmit framer, tracking each descriptor from ack to its eop word
module ast_tx_assertions
   import tx_stream_pkg::*;
(
   input logic              clk_in,
   input logic              rstn,
   input logic              tx_req,
   input logic              tx_ack,
   input logic [DATA_W-1:0] tx_desc,
   input logic              tx_ws,
   input logic              tx_err,
   input logic              tx_stream_ready,
   input logic              tx_stream_valid,
   input logic              stream_sop,
   input logic              stream_eop,
   input logic              stream_empty,
   input logic              stream_err,
   input logic [DATA_W-1:0] stream_data,
   input logic              tx_fifo_empty
);
   timeunit 1ns;
   timeprecision 1ps;

   // packets between ack and eop, far fewer than 64 at any time
   localparam int QD = 64;

   // expectation of the descriptor currently on tx_desc
   logic                  d_pl;
   logic                  d_hdr4;
   logic                  d_a2;
   logic [LEN_W-1:0]      d_len;
   logic [DW_COUNT_W-1:0] d_total;
   logic [DW_COUNT_W-1:0] d_words;
   logic                  d_empty;

   // packets in flight, written at ack and retired at eop
   logic [DW_COUNT_W-1:0] exp_words [QD];
   logic                  exp_empty [QD];
   logic                  exp_pl [QD];
   logic                  exp_err [QD];
   logic [DATA_W-1:0]     exp_desc [QD];
   logic [5:0]            wp;
   logic [5:0]            rp;
   logic [DW_COUNT_W-1:0] word_idx;
   logic                  cur_sop;
   logic                  cur_eop;
   int                    fail_count = 0;

   always_comb begin
      d_pl   = tx_desc[DESC_HAS_PAYLOAD_BIT];
      d_hdr4 = tx_desc[DESC_4DW_BIT];
      d_a2   = d_hdr4 ? tx_desc[ADDR4_LSB+2] : tx_desc[ADDR3_LSB+2];
      d_len  = tx_desc[DESC_LEN_LSB +: LEN_W];
      // header dwords, 3dw unaligned saves one, 4dw unaligned pads one
      if (!d_a2)
         d_total = DW_COUNT_W'(d_len) + DW_COUNT_W'(4);
      else if (d_hdr4)
         d_total = DW_COUNT_W'(d_len) + DW_COUNT_W'(5);
      else
         d_total = DW_COUNT_W'(d_len) + DW_COUNT_W'(3);
      d_words = d_pl ? (d_total + DW_COUNT_W'(3)) >> 2 : DW_COUNT_W'(1);
      if (!d_a2)
         d_empty = (d_len[1:0] == 2'd1) || (d_len[1:0] == 2'd2);
      else if (!d_hdr4)
         d_empty = (d_len[1:0] == 2'd2) || (d_len[1:0] == 2'd3);
      else
         d_empty = (d_len[1:0] == 2'd0) || (d_len[1:0] == 2'd1);
      d_empty = d_empty & d_pl;
   end

   // ------------------------------------------------------------------
   // expectation tracking
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         wp       <= '0;
         rp       <= '0;
         word_idx <= '0;
      end else begin
         if (tx_ack) begin
            exp_words[wp] <= d_words;
            exp_empty[wp] <= d_empty;
            exp_pl[wp]    <= d_pl;
            exp_err[wp]   <= tx_err;
            exp_desc[wp]  <= tx_desc;
            wp            <= wp + 1'b1;
         end
         if (tx_stream_valid) begin
            if (stream_eop) begin
               word_idx <= '0;
               rp       <= rp + 1'b1;
            end else begin
               word_idx <= word_idx + 1'b1;
            end
         end
      end
   end

   assign cur_sop = (word_idx == '0);
   assign cur_eop = (word_idx == exp_words[rp] - 1'b1);

   // ------------------------------------------------------------------
   // properties
   // ------------------------------------------------------------------
   a_reset: assert property (@(posedge clk_in)
      !rstn |=> (!tx_ack && !tx_ws && !tx_stream_valid && tx_fifo_empty))
      else begin
         fail_count++;
         $error("ack, wait-state, valid or FIFO empty not at reset value after reset");
      end

   a_ack_pulse: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_ack |=> !tx_ack)
      else begin
         fail_count++;
         $error("tx_ack held high for more than one cycle");
      end

   a_ack_cond: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_ack |-> (tx_req && !tx_ws))
      else begin
         fail_count++;
         $error("tx_ack raised without tx_req or during wait-state");
      end

   a_valid_ready: assert property (@(posedge clk_in) disable iff (!rstn)
      !tx_stream_ready |=> !tx_stream_valid)
      else begin
         fail_count++;
         $error("tx_stream_valid high after a cycle with ready low");
      end

   a_pending: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_stream_valid |-> (wp != rp))
      else begin
         fail_count++;
         $error("stream word seen with no acknowledged packet outstanding");
      end

   a_sop: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_stream_valid |-> (stream_sop == cur_sop))
      else begin
         fail_count++;
         $error("ERROR stream_sop %h expected %h", $sampled(stream_sop), $sampled(cur_sop));
      end

   a_eop: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_stream_valid |-> (stream_eop == cur_eop))
      else begin
         fail_count++;
         $error("ERROR stream_eop %h expected %h", $sampled(stream_eop), $sampled(cur_eop));
      end

   a_empty: assert property (@(posedge clk_in) disable iff (!rstn)
      (tx_stream_valid && stream_eop) |-> (stream_empty == exp_empty[rp]))
      else begin
         fail_count++;
         $error("ERROR stream_empty %h expected %h", $sampled(stream_empty),
                $sampled(exp_empty[rp]));
      end

   a_err: assert property (@(posedge clk_in) disable iff (!rstn)
      tx_stream_valid |-> (stream_err == exp_err[rp]))
      else begin
         fail_count++;
         $error("ERROR stream_err %h expected %h", $sampled(stream_err),
                $sampled(exp_err[rp]));
      end

   // header-only packet is the descriptor itself
   a_hdr_data: assert property (@(posedge clk_in) disable iff (!rstn)
      (tx_stream_valid && !exp_pl[rp]) |-> (stream_data == exp_desc[rp]))
      else begin
         fail_count++;
         $error("ERROR stream_data %h expected %h", $sampled(stream_data),
                $sampled(exp_desc[rp]));
      end

endmodule

//--- verif/ast_tx_tb.sv
// Testbench for the transmit framer, driving requester and link sides of the top level
module ast_tx_tb
   import tx_stream_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT  = 2000;
   // link ready modes
   localparam int RDY_HIGH = 0;
   localparam int RDY_GAPS = 1;
   localparam int RDY_LOW  = 2;

   logic              clk_in;
   logic              rstn;
   logic              tx_req;
   logic              tx_ack;
   logic [DATA_W-1:0] tx_desc;
   logic              tx_ws;
   logic              tx_err;
   logic              tx_dv;
   logic [DATA_W-1:0] tx_data;
   logic              tx_stream_ready;
   logic              tx_stream_valid;
   logic              stream_sop;
   logic              stream_eop;
   logic              stream_empty;
   logic              stream_err;
   logic [DATA_W-1:0] stream_data;
   logic              tx_fifo_empty;

   integer seed = 53326;
   int     ready_mode = RDY_HIGH;
   int     sent = 0;
   int     eop_seen = 0;
   int     test_errs;
   int     chk_base;
   int     n_pass = 0;
   int     n_fail = 0;

   ast_tx_top dut0 (.*);

   bind ast_tx_top ast_tx_assertions chk0 (.*);

   initial begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;
   end

   // ready changes 2 ns after the edge, after the requester inputs
   always @(posedge clk_in) begin
      #2;
      case (ready_mode)
         RDY_LOW:  tx_stream_ready = 1'b0;
         RDY_GAPS: tx_stream_ready = (($random(seed) % 4) != 0);
         default:  tx_stream_ready = 1'b1;
      endcase
   end

   // one eop per finished packet, valid is stable at the falling edge
   always @(negedge clk_in) begin
      if (rstn && tx_stream_valid && stream_eop)
         eop_seen++;
   end

   function automatic logic [DATA_W-1:0] rand_word();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic report_timeout(input string what);
      $display("timeout: no %s within %0d cycles", what, TIMEOUT);
      test_errs++;
   endtask

   // ------------------------------------------------------------------
   // requester
   // ------------------------------------------------------------------
   task automatic send_packet(input bit has_pl, input bit hdr4, input int len,
                              input logic [1:0] alo, input bit err);
      logic [DATA_W-1:0] desc;
      int                beats;
      int                t;
      desc = rand_word();
      desc[DATA_W-1] = 1'b0;
      desc[DESC_HAS_PAYLOAD_BIT] = has_pl;
      desc[DESC_4DW_BIT] = hdr4;
      desc[DESC_LEN_LSB +: LEN_W] = LEN_W'(len);
      if (hdr4)
         desc[ADDR4_LSB +: 4] = {alo, 2'b00};
      else
         desc[ADDR3_LSB +: 4] = {alo, 2'b00};
      // first beat starts at lane alo
      beats = has_pl ? (int'(alo) + len + 3) / 4 : 0;
      @(posedge clk_in);
      #1;
      tx_req  = 1'b1;
      tx_desc = desc;
      tx_err  = err;
      tx_dv   = has_pl;
      tx_data = rand_word();
      t = 0;
      @(negedge clk_in);
      while (!tx_ack && t < TIMEOUT) begin
         @(negedge clk_in);
         t++;
      end
      if (!tx_ack) begin
         report_timeout("tx_ack");
         tx_req = 1'b0;
         tx_dv  = 1'b0;
         return;
      end
      sent++;
      @(posedge clk_in);
      #1;
      tx_req = 1'b0;
      // remaining beats, each taken at an edge with tx_ws low
      for (int b = 1; b < beats; b++) begin
         tx_data = rand_word();
         t = 0;
         @(negedge clk_in);
         while (tx_ws && t < TIMEOUT) begin
            @(negedge clk_in);
            t++;
         end
         if (tx_ws) begin
            report_timeout("beat acceptance");
            tx_dv = 1'b0;
            return;
         end
         @(posedge clk_in);
         #1;
      end
      tx_dv = 1'b0;
   endtask

   task automatic drain_stream();
      int t;
      t = 0;
      while (eop_seen != sent && t < TIMEOUT) begin
         @(negedge clk_in);
         t++;
      end
      if (eop_seen != sent)
         report_timeout("end of packet on the stream");
      repeat (3) @(negedge clk_in);
   endtask

   task automatic start_test();
      test_errs = 0;
      chk_base  = dut0.chk0.fail_count;
   endtask

   task automatic close_test(input string name);
      int bad;
      bad = test_errs + (dut0.chk0.fail_count - chk_base);
      if (bad == 0) begin
         n_pass++;
         $display("test %s ok", name);
      end else begin
         n_fail++;
         $display("test %s failed with %0d errors", name, bad);
      end
   endtask

   // ------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------
   task automatic header_only_packets();
      ready_mode = RDY_HIGH;
      for (int i = 0; i < 4; i++)
         send_packet(1'b0, i[0], 1 + ($unsigned($random(seed)) % 12), 2'(i), i[1]);
      drain_stream();
   endtask

   // every alignment with both header sizes, then random lengths
   task automatic payload_alignment_sweep();
      ready_mode = RDY_GAPS;
      for (int h = 0; h < 2; h++)
         for (int a = 0; a < 4; a++)
            for (int l = 1; l <= 4; l++)
               send_packet(1'b1, h[0], l, a[1:0], 1'b0);
      for (int i = 0; i < 16; i++)
         send_packet(1'b1, $random(seed) & 1, 1 + ($unsigned($random(seed)) % 12),
                     2'($random(seed)), $random(seed) & 1);
      drain_stream();
   endtask

   task automatic link_stall_recovery();
      int t;
      ready_mode = RDY_LOW;
      fork
         begin
            for (int i = 0; i < 10; i++)
               send_packet(1'b1, i[0], 12, i[2:1], 1'b0);
         end
         begin
            t = 0;
            @(negedge clk_in);
            while (!tx_ws && t < TIMEOUT) begin
               @(negedge clk_in);
               t++;
            end
            if (!tx_ws) begin
               $display("tx_ws never rose while the link was stalled");
               test_errs++;
            end
            // keep the stall a little longer before releasing the link
            repeat (20) @(negedge clk_in);
            ready_mode = RDY_GAPS;
         end
      join
      drain_stream();
   endtask

   initial begin
      rstn            = 1'b0;
      tx_req          = 1'b0;
      tx_desc         = '0;
      tx_err          = 1'b0;
      tx_dv           = 1'b0;
      tx_data         = '0;
      tx_stream_ready = 1'b0;
      repeat (2) @(posedge clk_in);
      #1;
      rstn = 1'b1;

      start_test();
      repeat (4) @(negedge clk_in);
      close_test("reset");
      start_test();
      header_only_packets();
      close_test("header_only");
      start_test();
      payload_alignment_sweep();
      close_test("payload_sweep");
      start_test();
      link_stall_recovery();
      close_test("backpressure");

      $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
               n_pass + n_fail, n_pass, n_fail, dut0.chk0.fail_count);
      if (n_fail == 0 && dut0.chk0.fail_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- verilog/ast_tx_top.sv
// Transmit framer top level joining the TLP packer, the tx FIFO and the output stage
module ast_tx_top
   import tx_stream_pkg::*;
#(
   parameter int FIFO_DEPTH  = DEFAULT_FIFO_DEPTH,
   parameter int ALMOST_FULL = DEFAULT_ALMOST_FULL
) (
   input  logic              clk_in,
   input  logic              rstn,
   // requester
   input  logic              tx_req,
   output logic              tx_ack,
   input  logic [DATA_W-1:0] tx_desc,
   output logic              tx_ws,
   input  logic              tx_err,
   input  logic              tx_dv,
   input  logic [DATA_W-1:0] tx_data,
   // link
   input  logic              tx_stream_ready,
   output logic              tx_stream_valid,
   output logic              stream_sop,
   output logic              stream_eop,
   output logic              stream_empty,
   output logic              stream_err,
   output logic [DATA_W-1:0] stream_data,
   output logic              tx_fifo_empty
);

   logic              fifo_wr_en;
   logic              fifo_almost_full;
   logic              fifo_rd_en;
   logic              wr_sop;
   logic              wr_eop;
   logic              wr_empty;
   logic              wr_err;
   logic [DATA_W-1:0] wr_data;
   tx_word_t          wr_word;
   tx_word_t          rd_word;

   tlp_packer packer0 (
      .clk_in           (clk_in),
      .rstn             (rstn),
      .tx_req           (tx_req),
      .tx_ack           (tx_ack),
      .tx_desc          (tx_desc),
      .tx_ws            (tx_ws),
      .tx_err           (tx_err),
      .tx_dv            (tx_dv),
      .tx_data          (tx_data),
      .fifo_almost_full (fifo_almost_full),
      .fifo_wr_en       (fifo_wr_en),
      .wr_sop           (wr_sop),
      .wr_eop           (wr_eop),
      .wr_empty         (wr_empty),
      .wr_err           (wr_err),
      .wr_data          (wr_data)
   );

   // packer fields become one FIFO entry
   assign wr_word = '{err: wr_err, sop: wr_sop, eop: wr_eop, empty: wr_empty, data: wr_data};

   tx_fifo #(
      .DEPTH       (FIFO_DEPTH),
      .ALMOST_FULL (ALMOST_FULL),
      .payload_t   (tx_word_t)
   ) fifo0 (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .wr_en       (fifo_wr_en),
      .wr_data     (wr_word),
      .rd_en       (fifo_rd_en),
      .rd_data     (rd_word),
      .empty       (tx_fifo_empty),
      .almost_full (fifo_almost_full)
   );

   stream_out out0 (
      .clk_in          (clk_in),
      .rstn            (rstn),
      .fifo_empty      (tx_fifo_empty),
      .fifo_rd_en      (fifo_rd_en),
      .fifo_rd_data    (rd_word),
      .tx_stream_ready (tx_stream_ready),
      .tx_stream_valid (tx_stream_valid),
      .stream_sop      (stream_sop),
      .stream_eop      (stream_eop),
      .stream_empty    (stream_empty),
      .stream_err      (stream_err),
      .stream_data     (stream_data)
   );

endmodule

//--- verilog/stream_out.sv
// Output stage that drains the tx FIFO under link ready and registers the stream word
module stream_out
   import tx_stream_pkg::*;
(
   input  logic              clk_in,
   input  logic              rstn,
   input  logic              fifo_empty,
   output logic              fifo_rd_en,
   input  tx_word_t          fifo_rd_data,
   input  logic              tx_stream_ready,
   output logic              tx_stream_valid,
   output logic              stream_sop,
   output logic              stream_eop,
   output logic              stream_empty,
   output logic              stream_err,
   output logic [DATA_W-1:0] stream_data
);

   // a read word sits in the FIFO output register until a ready cycle moves it
   logic     landed;
   tx_word_t word_q;

   assign fifo_rd_en = tx_stream_ready & ~fifo_empty;

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         landed          <= 1'b0;
         tx_stream_valid <= 1'b0;
      end else if (tx_stream_ready) begin
         landed          <= fifo_rd_en;
         tx_stream_valid <= landed;
      end else begin
         // link stalled so hold the landed word and drop valid
         tx_stream_valid <= 1'b0;
      end
   end

   // stage only moves on a ready cycle with a landed word
   always_ff @(posedge clk_in) begin
      if (tx_stream_ready && landed)
         word_q <= fifo_rd_data;
   end

   assign stream_sop   = word_q.sop;
   assign stream_eop   = word_q.eop;
   assign stream_empty = word_q.empty;
   assign stream_err   = word_q.err;
   assign stream_data  = word_q.data;

endmodule

//--- verilog/tlp_packer.sv
// TLP packer that frames descriptors and payload beats into aligned 128-bit stream words
module tlp_packer
   import tx_stream_pkg::*;
(
   input  logic              clk_in,
   input  logic              rstn,
   // requester side
   // tx_desc is held from the rise of tx_req until tx_ack
   // for a packet with data the first beat is held on tx_data with tx_dv high
   // alongside the descriptor and is taken with tx_ack
   // the remaining beats follow, one per cycle with tx_dv high and tx_ws low
   // beats per packet is (address[3:2] + length + 3) / 4, dword 0 of the
   // first beat sits at lane address[3:2]
   input  logic              tx_req,
   output logic              tx_ack,
   input  logic [DATA_W-1:0] tx_desc,
   output logic              tx_ws,
   input  logic              tx_err,
   input  logic              tx_dv,
   input  logic [DATA_W-1:0] tx_data,
   // FIFO write side
   input  logic              fifo_almost_full,
   output logic              fifo_wr_en,
   output logic              wr_sop,
   output logic              wr_eop,
   output logic              wr_empty,
   output logic              wr_err,
   output logic [DATA_W-1:0] wr_data
);

   localparam int LANES = DATA_W / DW_W;

   // how far the stream lags the input beats, in dwords
   // none for 3dw header with address[3:2] of 3, full beat when D0 starts a new word
   typedef enum logic [1:0] {LAG_NONE, LAG_HALF, LAG_FULL} lag_t;

   // request edge and ack
   logic                  req_q;
   logic                  ack_pend;
   logic                  req_rise;
   logic                  busy;

   // descriptor fields caught at the request edge
   logic                  has_pl_q;
   logic                  hdr4_q;
   logic [LEN_W-1:0]      len_q;
   logic [1:0]            addr_lo_q;

   // per packet state
   lag_t                  lag_q;
   lag_t                  lag_n;
   logic                  pkt_err;
   logic [DATA_W-1:0]     prev_data;
   logic [DW_COUNT_W-1:0] dw_cnt;
   logic [LEN_W-1:0]      beats_left;
   logic                  extra_pend;

   // write event decode
   logic                  beat_acc;
   logic                  wr_event;
   logic                  hdr_only;
   logic                  last_beat;
   logic [DW_COUNT_W-1:0] hdr_dws;
   logic [DW_COUNT_W-1:0] total_dws;
   logic [DW_COUNT_W-1:0] n_beats;
   logic [DW_COUNT_W-1:0] cnt_cur;
   logic [DW_COUNT_W-1:0] cnt_next;
   logic                  eop_n;
   logic                  empty_n;
   logic                  err_n;
   logic [DW_W-1:0]       hdr_slot3;
   logic [DATA_W-1:0]     data_n;

   // payload beats arrive lane 0 first, stream puts the first dword on top
   function automatic logic [DATA_W-1:0] dw_swap(input logic [DATA_W-1:0] x);
      logic [DATA_W-1:0] y;
      for (int k = 0; k < LANES; k++) begin
         y[(LANES-1-k)*DW_W +: DW_W] = x[k*DW_W +: DW_W];
      end
      return y;
   endfunction

   // ---------------------------------------------------------------------
   // request handshake
   // ---------------------------------------------------------------------
   assign req_rise = tx_req & ~req_q;
   assign busy     = (beats_left != '0) | extra_pend;
   // no new header while beats or the trailing eop word are still owed
   assign tx_ack   = ack_pend & ~tx_ws & ~busy;

   always_ff @(posedge clk_in) begin
      if (req_rise) begin
         has_pl_q  <= tx_desc[DESC_HAS_PAYLOAD_BIT];
         hdr4_q    <= tx_desc[DESC_4DW_BIT];
         len_q     <= tx_desc[DESC_LEN_LSB +: LEN_W];
         addr_lo_q <= tx_desc[DESC_4DW_BIT] ? tx_desc[ADDR4_LSB+2 +: 2] :
                                              tx_desc[ADDR3_LSB+2 +: 2];
      end
   end

   // ---------------------------------------------------------------------
   // dword and beat counts
   // ---------------------------------------------------------------------
   // header plus pad dwords ahead of D0 in the stream
   always_comb begin
      case ({hdr4_q, addr_lo_q[0]})
         2'b01:   hdr_dws = DW_COUNT_W'(3);
         2'b11:   hdr_dws = DW_COUNT_W'(5);
         default: hdr_dws = DW_COUNT_W'(4);
      endcase
   end

   always_comb begin
      if (hdr4_q)
         lag_n = addr_lo_q[1] ? LAG_HALF : LAG_FULL;
      else if (addr_lo_q == 2'd0)
         lag_n = LAG_FULL;
      else if (addr_lo_q == 2'd3)
         lag_n = LAG_NONE;
      else
         lag_n = LAG_HALF;
   end

   assign total_dws = DW_COUNT_W'(len_q) + hdr_dws;
   assign n_beats   = (DW_COUNT_W'(len_q) + DW_COUNT_W'(addr_lo_q) + DW_COUNT_W'(3)) >> 2;

   // beats after the ack need both tx_dv and room in the FIFO
   assign beat_acc  = tx_dv & ~tx_ws & (beats_left != '0);
   assign wr_event  = tx_ack | beat_acc | extra_pend;
   assign hdr_only  = tx_ack & ~has_pl_q;
   assign last_beat = tx_ack ? (has_pl_q & (n_beats == DW_COUNT_W'(1))) :
                               (beat_acc & (beats_left == LEN_W'(1)));

   // remaining stream dwords decide eop, eop with two or fewer left is empty
   assign cnt_cur  = tx_ack ? total_dws : dw_cnt;
   assign cnt_next = (cnt_cur > DW_COUNT_W'(4)) ? cnt_cur - DW_COUNT_W'(4) : '0;
   assign eop_n    = hdr_only | (cnt_cur <= DW_COUNT_W'(4));
   assign empty_n  = eop_n & ~hdr_only & (cnt_cur <= DW_COUNT_W'(2));
   assign err_n    = tx_ack ? tx_err : (pkt_err | (beat_acc & tx_err));

   // ---------------------------------------------------------------------
   // stream data
   // ---------------------------------------------------------------------
   always_comb begin
      // 3dw header borrows D0 only when it lands in the fourth slot
      case (addr_lo_q)
         2'd1:    hdr_slot3 = tx_data[DW_W +: DW_W];
         2'd3:    hdr_slot3 = tx_data[3*DW_W +: DW_W];
         default: hdr_slot3 = '0;
      endcase
      if (tx_ack) begin
         if (has_pl_q && !hdr4_q)
            data_n = {tx_desc[DATA_W-1:DW_W], hdr_slot3};
         else
            data_n = tx_desc;
      end else begin
         case (lag_q)
            LAG_NONE: data_n = dw_swap(tx_data);
            // upper half of the last beat then lower half of this one
            LAG_HALF: data_n = {prev_data[2*DW_W +: DW_W], prev_data[3*DW_W +: DW_W],
                                tx_data[0 +: DW_W], tx_data[DW_W +: DW_W]};
            default:  data_n = dw_swap(prev_data);
         endcase
      end
   end

   always_ff @(posedge clk_in) begin
      if (tx_ack | beat_acc)
         prev_data <= tx_data;
      if (tx_ack)
         lag_q <= lag_n;
      if (wr_event)
         pkt_err <= err_n;
      wr_sop   <= tx_ack;
      wr_eop   <= eop_n;
      wr_empty <= empty_n;
      wr_err   <= err_n;
      wr_data  <= data_n;
   end

   // ---------------------------------------------------------------------
   // control state
   // ---------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         req_q      <= 1'b0;
         ack_pend   <= 1'b0;
         tx_ws      <= 1'b0;
         dw_cnt     <= '0;
         beats_left <= '0;
         extra_pend <= 1'b0;
         fifo_wr_en <= 1'b0;
      end else begin
         req_q <= tx_req;
         // wait-state follows almost-full one cycle late
         tx_ws <= fifo_almost_full;
         if (tx_ack)
            ack_pend <= 1'b0;
         else if (req_rise)
            ack_pend <= 1'b1;
         if (wr_event)
            dw_cnt <= cnt_next;
         if (tx_ack)
            beats_left <= has_pl_q ? n_beats[LEN_W-1:0] - LEN_W'(1) : '0;
         else if (beat_acc)
            beats_left <= beats_left - LEN_W'(1);
         // dwords still held after the last beat go out as one more eop word
         extra_pend <= last_beat & (cnt_next != '0);
         fifo_wr_en <= wr_event;
      end
   end

endmodule

//--- verilog/tx_fifo.sv
// Synchronous FIFO with registered read data and an almost-full threshold
module tx_fifo
   import tx_stream_pkg::*;
#(
   parameter int  DEPTH       = DEFAULT_FIFO_DEPTH,
   parameter int  ALMOST_FULL = DEFAULT_ALMOST_FULL,
   parameter type payload_t   = tx_word_t
) (
   input  logic     clk_in,
   input  logic     rstn,
   input  logic     wr_en,
   input  payload_t wr_data,
   input  logic     rd_en,
   output payload_t rd_data,
   output logic     empty,
   output logic     almost_full
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] FULL_LEVEL = DEPTH[AW:0];
   localparam logic [AW:0] AF_LEVEL   = ALMOST_FULL[AW:0];

   payload_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   // occupancy, one bit wider than the pointers
   logic [AW:0]   count;
   logic          full;
   logic          do_wr;
   logic          do_rd;

   // pointers wrap at DEPTH, which need not be a power of two
   function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
      logic [AW-1:0] last;
      last = AW'(DEPTH - 1);
      return (p == last) ? '0 : p + AW'(1);
   endfunction

   assign full        = (count == FULL_LEVEL);
   assign empty       = (count == '0);
   assign almost_full = (count >= AF_LEVEL);
   // overflow and underflow are ignored
   assign do_wr       = wr_en & ~full;
   assign do_rd       = rd_en & ~empty;

   // storage and the read register
   always_ff @(posedge clk_in) begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
      if (do_rd)
         rd_data <= mem[rd_ptr];
   end

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_rd)
            rd_ptr <= ptr_inc(rd_ptr);
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

endmodule

//--- verilog/tx_stream_pkg.sv
// Shared widths, descriptor field positions and stream word type of the PCIe transmit framer
package tx_stream_pkg;

   // ---------------------------------------------------------------------
   // data path widths
   // ---------------------------------------------------------------------
   localparam int DW_W       = 32;
   // one stream beat carries four dwords
   localparam int DATA_W     = 128;
   // payload length field in dwords
   localparam int LEN_W      = 10;
   // countdown covers length plus header and pad dwords
   localparam int DW_COUNT_W = 11;

   // ---------------------------------------------------------------------
   // descriptor fields
   // ---------------------------------------------------------------------
   // fmt bit 1, set when the TLP carries data
   localparam int DESC_HAS_PAYLOAD_BIT = 126;
   // fmt bit 0, set for a four dword header
   localparam int DESC_4DW_BIT         = 125;
   localparam int DESC_LEN_LSB         = 96;
   // address dword sits in H2 for 3dw headers and in H3 for 4dw headers
   localparam int ADDR3_LSB            = 32;
   localparam int ADDR4_LSB            = 0;

   // ---------------------------------------------------------------------
   // buffering defaults
   // ---------------------------------------------------------------------
   localparam int DEFAULT_FIFO_DEPTH  = 64;
   // leaves half the FIFO as headroom for words already in flight
   localparam int DEFAULT_ALMOST_FULL = 32;

   // one framed stream word, 132 bits
   typedef struct packed {
      logic              err;
      logic              sop;
      logic              eop;
      // low qword of an eop word carries no data
      logic              empty;
      logic [DATA_W-1:0] data;
   } tx_word_t;

endpackage
